//--- verilog/postadd_pkg.sv
package postadd_pkg;

    //////////////////////////////////////////////////////////////////////
    // Field geometry
    //////////////////////////////////////////////////////////////////////

    // Four 16-bit limbs per polynomial
    localparam int LIMBS      = 4;
    localparam int VAL_W      = 16;

    // Short unsigned carry on multiplier products
    localparam int CARRY_L1_W = 2;

    // Long signed carry inside the accumulators
    localparam int CARRY_L3_W = 8;

    // Normalized result, value is taken modulo 2^72
    localparam int ACC_W      = LIMBS * VAL_W + CARRY_L3_W;

    // Lane and register file sizes
    localparam int LANES      = 3;
    localparam int DEPTH      = 3;
    localparam int ADDR_W     = 2;

    // 2^64 - 59
    localparam logic [LIMBS*VAL_W-1:0] MOD_P = 64'hFFFF_FFFF_FFFF_FFC5;

    //////////////////////////////////////////////////////////////////////
    // Redundant limb types
    //////////////////////////////////////////////////////////////////////

    // Input limb, value = val + carry * 2^16
    typedef struct packed {
        logic [CARRY_L1_W-1:0] carry;
        logic [VAL_W-1:0]      val;
    } limb_l1_t;

    // Accumulator limb, carry is two's complement
    typedef struct packed {
        logic [CARRY_L3_W-1:0] carry;
        logic [VAL_W-1:0]      val;
    } limb_l3_t;

    // Limb 0 is the least significant
    typedef limb_l1_t [LIMBS-1:0] poly_l1_t;
    typedef limb_l3_t [LIMBS-1:0] poly_l3_t;

    // One lane's register file
    typedef poly_l3_t [DEPTH-1:0] lane_bank_t;

    // Modulus split into limbs with zero carries
    localparam poly_l3_t MOD_POLY = {
        8'h00, MOD_P[63:48],
        8'h00, MOD_P[47:32],
        8'h00, MOD_P[31:16],
        8'h00, MOD_P[15:0]
    };

    //////////////////////////////////////////////////////////////////////
    // Lane commands
    //////////////////////////////////////////////////////////////////////

    // Applied to the addressed entry
    typedef enum logic [2:0] {
        op_hold        = 3'd0,
        op_load        = 3'd1,
        op_add         = 3'd2,
        op_sub_from_in = 3'd3,
        op_sub_in      = 3'd4,
        op_neg_mod     = 3'd5
    } acc_op_e;

    typedef struct packed {
        acc_op_e           op;
        logic [ADDR_W-1:0] addr;
    } lane_cmd_t;

    // Index is the lane number
    typedef lane_cmd_t [LANES-1:0] lane_cmd_vec_t;

endpackage

//--- verilog/operand_stage.sv
`timescale 1ns/100ps

module operand_stage (
    input  logic                                clk,
    input  logic                                rstn,
    input  postadd_pkg::poly_l1_t               in_poly,
    input  postadd_pkg::lane_cmd_vec_t          cmds,
    input  logic                                rd_en,
    input  logic [postadd_pkg::ADDR_W-1:0]      rd_lane,
    input  logic [postadd_pkg::ADDR_W-1:0]      rd_addr,
    output postadd_pkg::poly_l3_t               operand,
    output postadd_pkg::lane_cmd_vec_t          cmds_q,
    output logic                                rd_en_q,
    output logic [postadd_pkg::ADDR_W-1:0]      rd_lane_q,
    output logic [postadd_pkg::ADDR_W-1:0]      rd_addr_q
);

    // Input polynomial with long carries
    postadd_pkg::poly_l3_t widened;

    // Carries are unsigned here, so zero fill keeps the value
    always_comb begin
        for (int i = 0; i < postadd_pkg::LIMBS; i++) begin
            widened[i].val   = in_poly[i].val;
            widened[i].carry = {
                {(postadd_pkg::CARRY_L3_W - postadd_pkg::CARRY_L1_W){1'b0}},
                in_poly[i].carry
            };
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Broadcast register
    //////////////////////////////////////////////////////////////////////

    // Commands and read strobe
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int l = 0; l < postadd_pkg::LANES; l++) begin
                cmds_q[l].op   <= postadd_pkg::op_hold;
                cmds_q[l].addr <= '0;
            end
            rd_en_q <= 1'b0;
        end else begin
            cmds_q  <= cmds;
            rd_en_q <= rd_en;
        end
    end

    // Operand and read address, qualified by the fields above
    always_ff @(posedge clk) begin
        operand   <= widened;
        rd_lane_q <= rd_lane;
        rd_addr_q <= rd_addr;
    end

endmodule

//--- verilog/redundant_adder.sv
`timescale 1ns/100ps

module redundant_adder (
    input  logic                  sub,
    input  postadd_pkg::poly_l3_t x,
    input  postadd_pkg::poly_l3_t y,
    output postadd_pkg::poly_l3_t z
);

    // Per-limb sum, three guard bits over the value field
    logic signed [postadd_pkg::VAL_W+2:0] term [postadd_pkg::LIMBS];

    // Limb value as a positive term
    function automatic logic signed [postadd_pkg::VAL_W+2:0] ext_val(
        input logic [postadd_pkg::VAL_W-1:0] v
    );
        return $signed({3'b000, v});
    endfunction

    // Sign extended carry
    function automatic logic signed [postadd_pkg::VAL_W+2:0] ext_carry(
        input logic [postadd_pkg::CARRY_L3_W-1:0] c
    );
        return $signed({
            {(postadd_pkg::VAL_W + 3 - postadd_pkg::CARRY_L3_W){c[postadd_pkg::CARRY_L3_W-1]}},
            c
        });
    endfunction

    function automatic logic signed [postadd_pkg::VAL_W+2:0] addsub(
        input logic signed [postadd_pkg::VAL_W+2:0] a,
        input logic signed [postadd_pkg::VAL_W+2:0] b,
        input logic                                 s
    );
        return s ? (a - b) : (a + b);
    endfunction

    always_comb begin
        // Limb 0 has nothing coming in from below
        term[0] = addsub(ext_val(x[0].val), ext_val(y[0].val), sub);

        // Carries of limb i-1 carry weight 2^(16*i), fold them into limb i
        for (int i = 1; i < postadd_pkg::LIMBS; i++) begin
            term[i] = addsub(ext_val(x[i].val), ext_val(y[i].val), sub)
                    + addsub(ext_carry(x[i-1].carry), ext_carry(y[i-1].carry), sub);
        end

        // Split each term into low value bits and a small signed carry
        for (int i = 0; i < postadd_pkg::LIMBS; i++) begin
            z[i].val   = term[i][postadd_pkg::VAL_W-1:0];
            z[i].carry = {
                {(postadd_pkg::CARRY_L3_W - 3){term[i][postadd_pkg::VAL_W+2]}},
                term[i][postadd_pkg::VAL_W+2:postadd_pkg::VAL_W]
            };
        end

        // Top carries stay at weight 2^64
        // wrapping at 8 bits is exact modulo 2^72
        z[postadd_pkg::LIMBS-1].carry = z[postadd_pkg::LIMBS-1].carry
            + (sub ? (x[postadd_pkg::LIMBS-1].carry - y[postadd_pkg::LIMBS-1].carry)
                   : (x[postadd_pkg::LIMBS-1].carry + y[postadd_pkg::LIMBS-1].carry));
    end

endmodule

//--- verilog/acc_lane.sv
`timescale 1ns/100ps

module acc_lane (
    input  logic                    clk,
    input  logic                    rstn,
    input  postadd_pkg::poly_l3_t   operand,
    input  postadd_pkg::lane_cmd_t  cmd,
    output postadd_pkg::lane_bank_t entries
);

    // Entry under the current address, before this cycle's write
    postadd_pkg::poly_l3_t cur_entry;

    // Adder operands and result
    postadd_pkg::poly_l3_t add_x;
    postadd_pkg::poly_l3_t add_y;
    postadd_pkg::poly_l3_t sum;
    logic                  add_sub;
    logic                  wr_en;

    // Unused address 3 reads as zero
    assign cur_entry = (cmd.addr < postadd_pkg::DEPTH) ? entries[cmd.addr] : '0;

    //////////////////////////////////////////////////////////////////////
    // Opcode decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        // Default is 0 + entry
        add_x   = '0;
        add_y   = cur_entry;
        add_sub = 1'b0;
        wr_en   = 1'b1;
        case (cmd.op)
            // 0 + in
            postadd_pkg::op_load: begin
                add_y = operand;
            end
            // in + entry
            postadd_pkg::op_add: begin
                add_x = operand;
            end
            // in - entry
            postadd_pkg::op_sub_from_in: begin
                add_x   = operand;
                add_sub = 1'b1;
            end
            // entry - in
            postadd_pkg::op_sub_in: begin
                add_x   = cur_entry;
                add_y   = operand;
                add_sub = 1'b1;
            end
            // P - entry
            postadd_pkg::op_neg_mod: begin
                add_x   = postadd_pkg::MOD_POLY;
                add_sub = 1'b1;
            end
            // Hold and the spare codes
            default: begin
                wr_en = 1'b0;
            end
        endcase
        if (cmd.addr >= postadd_pkg::DEPTH) begin
            wr_en = 1'b0;
        end
    end

    redundant_adder redundant_adder_i (
        .sub (add_sub),
        .x   (add_x),
        .y   (add_y),
        .z   (sum)
    );

    //////////////////////////////////////////////////////////////////////
    // Register file
    //////////////////////////////////////////////////////////////////////

    // Entries start at zero
    always_ff @(posedge clk) begin
        if (!rstn) begin
            entries <= '0;
        end else if (wr_en) begin
            entries[cmd.addr] <= sum;
        end
    end

    // Upstream never addresses the spare slot with a live op
    a_cmd_addr: assert property (
        @(posedge clk) disable iff (!rstn)
        (cmd.op != postadd_pkg::op_hold) |-> (cmd.addr < postadd_pkg::DEPTH)
    ) else $error("acc_lane: op %0d on address %0d", cmd.op, cmd.addr);

endmodule

//--- verilog/result_drain.sv
`timescale 1ns/100ps

module result_drain (
    input  logic                                          clk,
    input  logic                                          rstn,
    input  postadd_pkg::lane_bank_t [postadd_pkg::LANES-1:0] lane_entries,
    input  logic                                          rd_en,
    input  logic [postadd_pkg::ADDR_W-1:0]                rd_lane,
    input  logic [postadd_pkg::ADDR_W-1:0]                rd_addr,
    output logic [postadd_pkg::ACC_W-1:0]                 out_value,
    output logic                                          out_valid
);

    // Stage 1, chosen entry still in limb form
    postadd_pkg::poly_l3_t pick;
    postadd_pkg::poly_l3_t pick_q;
    logic                  pick_valid;

    // Stage 2 input, full-width integer
    logic [postadd_pkg::ACC_W-1:0] norm;

    // Limb value placed at its weight
    function automatic logic [postadd_pkg::ACC_W-1:0] place_val(
        input logic [postadd_pkg::VAL_W-1:0] v,
        input int                            i
    );
        logic [postadd_pkg::ACC_W-1:0] w;
        w = '0;
        w[postadd_pkg::VAL_W-1:0] = v;
        return w << (postadd_pkg::VAL_W * i);
    endfunction

    // Signed carry placed one limb higher
    function automatic logic [postadd_pkg::ACC_W-1:0] place_carry(
        input logic [postadd_pkg::CARRY_L3_W-1:0] c,
        input int                                 i
    );
        logic [postadd_pkg::ACC_W-1:0] w;
        w = {{(postadd_pkg::ACC_W - postadd_pkg::CARRY_L3_W){c[postadd_pkg::CARRY_L3_W-1]}}, c};
        return w << (postadd_pkg::VAL_W * (i + 1));
    endfunction

    // Out-of-range lane or address reads zero
    always_comb begin
        pick = '0;
        if (rd_lane < postadd_pkg::LANES && rd_addr < postadd_pkg::DEPTH) begin
            pick = lane_entries[rd_lane][rd_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pick_valid <= 1'b0;
        end else begin
            pick_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            pick_q <= pick;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Carry resolve
    //////////////////////////////////////////////////////////////////////

    // Negative carries borrow through the whole width, modulo 2^72
    always_comb begin
        norm = '0;
        for (int i = 0; i < postadd_pkg::LIMBS; i++) begin
            norm = norm + place_val(pick_q[i].val, i) + place_carry(pick_q[i].carry, i);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= pick_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (pick_valid) begin
            out_value <= norm;
        end
    end

    // Read requests from outside stay inside the lane array
    a_rd_range: assert property (
        @(posedge clk) disable iff (!rstn)
        rd_en |-> (rd_lane < postadd_pkg::LANES && rd_addr < postadd_pkg::DEPTH)
    ) else $error("result_drain: read lane %0d addr %0d", rd_lane, rd_addr);

endmodule

//--- verilog/postadd_unit.sv
`timescale 1ns/100ps

module postadd_unit (
    input  logic                            clk,
    input  logic                            rstn,
    input  postadd_pkg::poly_l1_t           in_poly,
    input  postadd_pkg::lane_cmd_vec_t      cmds,
    input  logic                            rd_en,
    input  logic [postadd_pkg::ADDR_W-1:0]  rd_lane,
    input  logic [postadd_pkg::ADDR_W-1:0]  rd_addr,
    output logic [postadd_pkg::ACC_W-1:0]   out_value,
    output logic                            out_valid
);

    // Staged operand and controls, one cycle after the pins
    postadd_pkg::poly_l3_t               operand;
    postadd_pkg::lane_cmd_vec_t          cmds_q;
    logic                                rd_en_q;
    logic [postadd_pkg::ADDR_W-1:0]      rd_lane_q;
    logic [postadd_pkg::ADDR_W-1:0]      rd_addr_q;

    // Every lane's register file
    postadd_pkg::lane_bank_t [postadd_pkg::LANES-1:0] lane_entries;

    operand_stage operand_stage_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_poly   (in_poly),
        .cmds      (cmds),
        .rd_en     (rd_en),
        .rd_lane   (rd_lane),
        .rd_addr   (rd_addr),
        .operand   (operand),
        .cmds_q    (cmds_q),
        .rd_en_q   (rd_en_q),
        .rd_lane_q (rd_lane_q),
        .rd_addr_q (rd_addr_q)
    );

    // Same operand to all lanes, own command each
    for (genvar g = 0; g < postadd_pkg::LANES; g++) begin : g_lane
        acc_lane acc_lane_i (
            .clk     (clk),
            .rstn    (rstn),
            .operand (operand),
            .cmd     (cmds_q[g]),
            .entries (lane_entries[g])
        );
    end

    // Reads see entries before the write of the same staged cycle
    result_drain result_drain_i (
        .clk          (clk),
        .rstn         (rstn),
        .lane_entries (lane_entries),
        .rd_en        (rd_en_q),
        .rd_lane      (rd_lane_q),
        .rd_addr      (rd_addr_q),
        .out_value    (out_value),
        .out_valid    (out_valid)
    );

endmodule

//--- include/postadd_ref.svh
`ifndef POSTADD_REF_SVH
`define POSTADD_REF_SVH

//////////////////////////////////////////////////////////////////////
// Stimulus source
//////////////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 16 14 13 11
logic [15:0] lfsr_state = 16'd37242;

// One step per bit, newest bit lands in bit 0
function automatic logic [31:0] lfsr_take(input int unsigned nbits);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int unsigned n = 0; n < nbits; n++) begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        bits       = {bits[30:0], fb};
    end
    return bits;
endfunction

// Random input, carries included
function automatic postadd_pkg::poly_l1_t lfsr_poly();
    postadd_pkg::poly_l1_t p;
    logic [31:0]           bits;
    for (int i = 0; i < postadd_pkg::LIMBS; i++) begin
        bits       = lfsr_take(postadd_pkg::VAL_W);
        p[i].val   = bits[postadd_pkg::VAL_W-1:0];
        bits       = lfsr_take(postadd_pkg::CARRY_L1_W);
        p[i].carry = bits[postadd_pkg::CARRY_L1_W-1:0];
    end
    return p;
endfunction

// Represented value of an input polynomial
function automatic logic [postadd_pkg::ACC_W-1:0] poly_l1_value(
    input postadd_pkg::poly_l1_t p
);
    logic [postadd_pkg::ACC_W-1:0] sum;
    logic [postadd_pkg::ACC_W-1:0] limb;
    sum = '0;
    for (int i = 0; i < postadd_pkg::LIMBS; i++) begin
        limb = '0;
        limb[postadd_pkg::VAL_W+postadd_pkg::CARRY_L1_W-1:0] = {p[i].carry, p[i].val};
        sum  = sum + (limb << (postadd_pkg::VAL_W * i));
    end
    return sum;
endfunction

//////////////////////////////////////////////////////////////////////
// Software entries
//////////////////////////////////////////////////////////////////////

// Nine integers, modulo 2^72
logic [postadd_pkg::ACC_W-1:0] ref_entry [postadd_pkg::LANES][postadd_pkg::DEPTH];

function automatic void ref_clear();
    for (int l = 0; l < postadd_pkg::LANES; l++) begin
        for (int a = 0; a < postadd_pkg::DEPTH; a++) begin
            ref_entry[l][a] = '0;
        end
    end
endfunction

// Same opcode rules as the lanes
function automatic void ref_apply(
    input int                            lane,
    input postadd_pkg::lane_cmd_t        cmd,
    input logic [postadd_pkg::ACC_W-1:0] in_value
);
    logic [postadd_pkg::ACC_W-1:0] e;
    logic [postadd_pkg::ACC_W-1:0] p_ext;
    if (cmd.op == postadd_pkg::op_hold || cmd.addr >= postadd_pkg::DEPTH) begin
        return;
    end
    p_ext = postadd_pkg::MOD_P;
    e     = ref_entry[lane][cmd.addr];
    case (cmd.op)
        postadd_pkg::op_load:        e = in_value;
        postadd_pkg::op_add:         e = in_value + e;
        postadd_pkg::op_sub_from_in: e = in_value - e;
        postadd_pkg::op_sub_in:      e = e - in_value;
        postadd_pkg::op_neg_mod:     e = p_ext - e;
        default:                     e = ref_entry[lane][cmd.addr];
    endcase
    ref_entry[lane][cmd.addr] = e;
endfunction

`endif

//--- bench/postadd_tb.sv
`timescale 1ns/100ps

module postadd_tb;

    //////////////////////////////////////////////////////////////////////
    // Cycle budget
    //////////////////////////////////////////////////////////////////////

    // Nine reads plus room for the 3-cycle pipe to empty
    localparam int READ_ALL_CYCLES = 9 + 6;
    localparam int ADDSUB_CYCLES   = 48;
    localparam int HOLD_CYCLES     = 12;
    localparam int CYCLE_LIMIT     = (3 + READ_ALL_CYCLES) + (9 + READ_ALL_CYCLES)
                                   + (ADDSUB_CYCLES + READ_ALL_CYCLES) + (4 + READ_ALL_CYCLES)
                                   + (HOLD_CYCLES + READ_ALL_CYCLES) + (6 + 6) + 20;

    logic                                  clk;
    logic                                  rstn;
    postadd_pkg::poly_l1_t                 in_poly;
    postadd_pkg::lane_cmd_vec_t            cmds;
    logic                                  rd_en;
    logic [postadd_pkg::ADDR_W-1:0]        rd_lane;
    logic [postadd_pkg::ADDR_W-1:0]        rd_addr;
    logic [postadd_pkg::ACC_W-1:0]         out_value;
    logic                                  out_valid;

    // Model value of the entry read this cycle and its trip down the pipe
    logic [postadd_pkg::ACC_W-1:0]         exp_now;
    logic [postadd_pkg::ACC_W-1:0]         exp_pipe [3];

    int errors       = 0;
    int reads_issued = 0;
    int reads_seen   = 0;
    int tests_run    = 0;
    int cycle_count  = 0;

    `include "postadd_ref.svh"

    postadd_unit postadd_unit_i (
        .clk       (clk),
        .rstn      (rstn),
        .in_poly   (in_poly),
        .cmds      (cmds),
        .rd_en     (rd_en),
        .rd_lane   (rd_lane),
        .rd_addr   (rd_addr),
        .out_value (out_value),
        .out_valid (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Expected values follow the DUT latency
    always @(posedge clk) begin
        exp_pipe[0] <= exp_now;
        exp_pipe[1] <= exp_pipe[0];
        exp_pipe[2] <= exp_pipe[1];
    end

    // Results counted mid-cycle where out_valid is stable
    always @(negedge clk) begin
        if (rstn && out_valid) begin
            reads_seen++;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    a_out_value: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid |-> (out_value == exp_pipe[2])
    ) else begin
        errors++;
        $display("[ERROR] %0t out_value: got %h expected %h",
                 $time, $sampled(out_value), $sampled(exp_pipe[2]));
    end

    // Exactly one result per read, three cycles later
    a_out_valid: assert property (
        @(posedge clk) disable iff (!rstn)
        out_valid == $past(rd_en, 3)
    ) else begin
        errors++;
        $display("[ERROR] %0t out_valid: got %b expected %b",
                 $time, $sampled(out_valid), $past(rd_en, 3));
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////////////////////////

    function automatic postadd_pkg::lane_cmd_vec_t single_cmd(
        input int lane, input postadd_pkg::acc_op_e op, input int addr
    );
        postadd_pkg::lane_cmd_vec_t v;
        v            = '0;
        v[lane].op   = op;
        v[lane].addr = 2'(addr);
        return v;
    endfunction

    // Lane or entry index 0..2
    function automatic int rand_index();
        logic [31:0] r;
        r = lfsr_take(4);
        return int'(r % 3);
    endfunction

    function automatic postadd_pkg::acc_op_e rand_op();
        logic [31:0] r;
        r = lfsr_take(2);
        case (r[1:0])
            2'd1:    return postadd_pkg::op_sub_from_in;
            2'd2:    return postadd_pkg::op_sub_in;
            default: return postadd_pkg::op_add;
        endcase
    endfunction

    // One cycle of inputs with the model read ahead of the commands
    task automatic drive_cycle(
        input postadd_pkg::poly_l1_t      p,
        input postadd_pkg::lane_cmd_vec_t c,
        input logic                       re,
        input int                         lane,
        input int                         addr
    );
        @(posedge clk);
        #2;
        in_poly = p;
        cmds    = c;
        rd_en   = re;
        rd_lane = 2'(lane);
        rd_addr = 2'(addr);
        if (re) begin
            exp_now = ref_entry[lane][addr];
            reads_issued++;
        end
        for (int l = 0; l < postadd_pkg::LANES; l++) begin
            ref_apply(l, c[l], poly_l1_value(p));
        end
    endtask

    task automatic read_all();
        for (int l = 0; l < postadd_pkg::LANES; l++) begin
            for (int a = 0; a < postadd_pkg::DEPTH; a++) begin
                drive_cycle('0, '0, 1'b1, l, a);
            end
        end
    endtask

    // Idle until every read has come back
    task automatic drain_reads();
        drive_cycle('0, '0, 1'b0, 0, 0);
        while (reads_seen != reads_issued) begin
            @(posedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic report_test(input string name, input int err_start);
        drain_reads();
        tests_run++;
        if (errors == err_start) begin
            $display("%-12s ok, %0d reads so far", name, reads_seen);
        end else begin
            $display("%-12s %0d errors", name, errors - err_start);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////

    task automatic test_load();
        postadd_pkg::poly_l1_t p;
        int                    err_start;
        err_start = errors;
        for (int l = 0; l < postadd_pkg::LANES; l++) begin
            for (int a = 0; a < postadd_pkg::DEPTH; a++) begin
                p = lfsr_poly();
                // Largest input with every carry at its top
                if (l == 0 && a == 0) begin
                    p = '1;
                end
                drive_cycle(p, single_cmd(l, postadd_pkg::op_load, a), 1'b0, 0, 0);
            end
        end
        read_all();
        report_test("load", err_start);
    endtask

    task automatic test_add_sub();
        postadd_pkg::lane_cmd_vec_t c;
        logic [31:0]                r;
        int                         err_start;
        err_start = errors;
        for (int n = 0; n < ADDSUB_CYCLES; n++) begin
            for (int l = 0; l < postadd_pkg::LANES; l++) begin
                c[l].op   = rand_op();
                c[l].addr = 2'(rand_index());
            end
            r = lfsr_take(1);
            drive_cycle(lfsr_poly(), c, r[0], rand_index(), rand_index());
        end
        read_all();
        report_test("add_sub", err_start);
    endtask

    task automatic test_neg_mod();
        postadd_pkg::lane_cmd_vec_t c;
        int                         err_start;
        err_start = errors;
        // All lanes at once with one address per cycle
        for (int a = 0; a < postadd_pkg::DEPTH; a++) begin
            for (int l = 0; l < postadd_pkg::LANES; l++) begin
                c[l].op   = postadd_pkg::op_neg_mod;
                c[l].addr = 2'(a);
            end
            drive_cycle('0, c, 1'b0, 0, 0);
        end
        // Twice in a row gives the entry back
        drive_cycle('0, single_cmd(0, postadd_pkg::op_neg_mod, 0), 1'b0, 0, 0);
        read_all();
        report_test("neg_mod", err_start);
    endtask

    task automatic test_hold();
        int err_start;
        int other;
        err_start = errors;
        for (int n = 0; n < HOLD_CYCLES; n++) begin
            // Only lane 1 writes while lanes 0 and 2 are watched
            other = (n % 2 == 0) ? 0 : 2;
            drive_cycle(lfsr_poly(), single_cmd(1, rand_op(), rand_index()),
                        1'b1, other, rand_index());
        end
        read_all();
        report_test("hold", err_start);
    endtask

    task automatic test_same_cycle();
        int err_start;
        err_start = errors;
        for (int l = 0; l < postadd_pkg::LANES; l++) begin
            // Old value first and the written one next
            drive_cycle(lfsr_poly(), single_cmd(l, postadd_pkg::op_add, 1), 1'b1, l, 1);
            drive_cycle('0, '0, 1'b1, l, 1);
        end
        report_test("same_cycle", err_start);
    endtask

    initial begin
        int err_start;
        rstn    = 1'b0;
        in_poly = '0;
        cmds    = '0;
        rd_en   = 1'b0;
        rd_lane = '0;
        rd_addr = '0;
        exp_now = '0;
        ref_clear();

        repeat (3) @(posedge clk);
        #2;
        rstn = 1'b1;

        // Reset leaves all nine entries at zero
        err_start = errors;
        read_all();
        report_test("reset", err_start);

        test_load();
        test_add_sub();
        test_neg_mod();
        test_hold();
        test_same_cycle();

        $display("Summary: %0d tests, %0d reads checked, %0d errors",
                 tests_run, reads_seen, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- postadd_unit.f
+incdir+include
verilog/postadd_pkg.sv
verilog/operand_stage.sv
verilog/redundant_adder.sv
verilog/acc_lane.sv
verilog/result_drain.sv
verilog/postadd_unit.sv
bench/postadd_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the post-add unit testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module postadd_tb -f postadd_unit.f \
    --Mdir obj_dir -o postadd_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/postadd_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
exit 1
